// ==== tb.f ====
+incdir+test
design/noc_pkg.sv
design/port_fifo.sv
design/rr_arbiter.sv
design/west_east_merge.sv
test/tb_merge.sv

// ==== Makefile ====
# Verilator build and run of the west/east merge testbench

VERILATOR ?= verilator
TOP       ?= tb_merge
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing

SRCS := $(wildcard design/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_util.svh ====
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Pick encoding of the reference arbiter
// Bit 0 is the west read and bit 1 the east read
localparam logic [1:0] PICK_NONE = 2'b00;
localparam logic [1:0] PICK_WEST = 2'b01;
localparam logic [1:0] PICK_EAST = 2'b10;

///////////////////////////////
// Random source
///////////////////////////////

// 32-bit Fibonacci LFSR with taps 32 22 2 1
// One call gives one new bit in bit 0
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

///////////////////////////////
// Reference arbitration
///////////////////////////////

// Round-robin pick between the two ports
// Nothing is read while drain is low
// A lone requester wins and a tie goes to the port not granted last
function automatic logic [1:0] arbitrate(
    input logic   drain,
    input logic   west_busy,
    input logic   east_busy,
    input grant_e last
);
    logic [1:0] pick;
    pick = PICK_NONE;
    if (drain)
    begin
        if (west_busy && east_busy)
            pick = (last == LAST_EAST) ? PICK_WEST : PICK_EAST;
        else if (west_busy)
            pick = PICK_WEST;
        else if (east_busy)
            pick = PICK_EAST;
    end
    return pick;
endfunction

///////////////////////////////
// Value check
///////////////////////////////

// Compare one observed value with its expected value
task automatic check_value(
    input string       name,
    input logic [31:0] actual,
    input logic [31:0] expected
);
    if (actual !== expected)
    begin
        $display("ERR %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
        stop_failed();
    end
endtask

`endif

// ==== test/tb_merge.sv ====
`default_nettype none

module tb_merge
    import noc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Test lengths in cycles
    localparam int RESET_CYCLES   = 10;
    localparam int FILL_WRITES    = FIFO_DEPTH + 4;
    localparam int SINGLE_CYCLES  = 8;
    localparam int RANDOM_CYCLES  = 2000;
    localparam int DRAIN_CYCLES   = 2 * FIFO_DEPTH + 8;
    localparam int STIM_CYCLES    = RESET_CYCLES + FILL_WRITES + 2 * SINGLE_CYCLES
                                    + RANDOM_CYCLES + 3 * DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + FIFO_DEPTH * 4;

    localparam logic [31:0] LFSR_SEED = 32'hf052_b3a8;

    logic         clk;
    logic         rst_n;
    logic         west_wr_en;
    payload_t     west_din;
    logic         east_wr_en;
    payload_t     east_din;
    logic         drain_en;
    logic         out_valid;
    flit_t        out_flit;
    fifo_status_t west_status;
    fifo_status_t east_status;

    // Reference model
    // Queues hold every accepted word not yet seen at the output
    payload_t west_q[$];
    payload_t east_q[$];
    int       west_cnt;
    int       east_cnt;
    grant_e   last_m;
    logic     pend_m;
    port_e    pend_src_m;
    logic     valid_m;
    port_e    src_m;
    logic [1:0] pick;
    logic     west_acc;
    logic     east_acc;
    payload_t exp_data;

    // Run bookkeeping
    int          cycle;
    int          flits_seen;
    int          last_valid_cycle;
    flit_t       last_flit;
    logic        alt_on;
    int          alt_idx;
    logic [31:0] lfsr_state;

    task automatic stop_failed();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

`include "tb_util.svh"

    // Take n fresh LFSR bits with one step per bit
    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    west_east_merge DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .west_wr_en  (west_wr_en),
        .west_din    (west_din),
        .east_wr_en  (east_wr_en),
        .east_din    (east_din),
        .drain_en    (drain_en),
        .out_valid   (out_valid),
        .out_flit    (out_flit),
        .west_status (west_status),
        .east_status (east_status)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run was still busy after %0d cycles", cycle);
            stop_failed();
        end
    end

    ///////////////////////////////
    // Reference model
    ///////////////////////////////

    // Steps on the same edge as the DUT with the inputs it samples
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            west_q.delete();
            east_q.delete();
            west_cnt   = 0;
            east_cnt   = 0;
            last_m     = LAST_EAST;
            pend_m     = 1'b0;
            pend_src_m = PORT_WEST;
            valid_m    = 1'b0;
            src_m      = PORT_WEST;
        end
        else
        begin
            pick     = arbitrate(drain_en, west_cnt != 0, east_cnt != 0, last_m);
            // A full port drops the write even when it is read this cycle
            west_acc = west_wr_en && (west_cnt < FIFO_DEPTH);
            east_acc = east_wr_en && (east_cnt < FIFO_DEPTH);
            // Output follows the pending stage by one edge
            valid_m = pend_m;
            if (pend_m)
                src_m = pend_src_m;
            pend_m = (pick != PICK_NONE);
            if (pick == PICK_WEST)
            begin
                pend_src_m = PORT_WEST;
                last_m     = LAST_WEST;
            end
            else if (pick == PICK_EAST)
            begin
                pend_src_m = PORT_EAST;
                last_m     = LAST_EAST;
            end
            if (west_acc)
                west_q.push_back(west_din);
            if (east_acc)
                east_q.push_back(east_din);
            west_cnt = west_cnt + (west_acc ? 1 : 0) - ((pick == PICK_WEST) ? 1 : 0);
            east_cnt = east_cnt + (east_acc ? 1 : 0) - ((pick == PICK_EAST) ? 1 : 0);
        end
    end

    ///////////////////////////////
    // Comparison
    ///////////////////////////////

    // Outputs are settled at the falling edge
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            check_value("west_status.count", 32'(west_status.count), 32'(west_cnt));
            check_value("west_status.empty", 32'(west_status.empty), 32'(west_cnt == 0));
            check_value("west_status.full", 32'(west_status.full), 32'(west_cnt == FIFO_DEPTH));
            check_value("east_status.count", 32'(east_status.count), 32'(east_cnt));
            check_value("east_status.empty", 32'(east_status.empty), 32'(east_cnt == 0));
            check_value("east_status.full", 32'(east_status.full), 32'(east_cnt == FIFO_DEPTH));
            check_value("out_valid", 32'(out_valid), 32'(valid_m));
            if (valid_m)
            begin
                if ((src_m == PORT_WEST) ? (west_q.size() == 0) : (east_q.size() == 0))
                begin
                    $display("A flit came out with no word queued for its source port");
                    stop_failed();
                end
                else
                begin
                    exp_data = (src_m == PORT_WEST) ? west_q.pop_front() : east_q.pop_front();
                    check_value("out_flit.src", 32'(out_flit.src), 32'(src_m));
                    check_value("out_flit.data", 32'(out_flit.data), 32'(exp_data));
                    // With both ports full the sources must take turns from west
                    if (alt_on)
                    begin
                        check_value("out_flit.src turn", 32'(out_flit.src),
                                    32'((alt_idx % 2 == 0) ? PORT_WEST : PORT_EAST));
                        alt_idx++;
                    end
                    flits_seen++;
                    last_valid_cycle = cycle;
                    last_flit = out_flit;
                end
            end
        end
    end

    ///////////////////////////////
    // Stimulus
    ///////////////////////////////

    // Queues only drain once the writes have been off for an edge
    task automatic wait_idle();
        @(posedge clk);
        while (west_q.size() != 0 || east_q.size() != 0)
            @(posedge clk);
    endtask

    // Overfill both ports with the output held
    task automatic fill_ports();
        logic [31:0] bits;
        repeat (FILL_WRITES)
        begin
            @(posedge clk);
            draw_bits(PAYLOAD_W, bits);
            west_wr_en <= 1'b1;
            west_din   <= bits[PAYLOAD_W-1:0];
            draw_bits(PAYLOAD_W, bits);
            east_wr_en <= 1'b1;
            east_din   <= bits[PAYLOAD_W-1:0];
        end
        @(posedge clk);
        west_wr_en <= 1'b0;
        east_wr_en <= 1'b0;
        @(negedge clk);
        check_value("west_status.full", 32'(west_status.full), 32'd1);
        check_value("west_status.count", 32'(west_status.count), 32'(FIFO_DEPTH));
        check_value("east_status.full", 32'(east_status.full), 32'd1);
        check_value("east_status.count", 32'(east_status.count), 32'(FIFO_DEPTH));
    endtask

    // Release the output with both ports full
    task automatic drain_alternating();
        alt_idx = 0;
        alt_on  = 1'b1;
        @(posedge clk);
        drain_en <= 1'b1;
        wait_idle();
        alt_on = 1'b0;
    endtask

    // One write into an idle port gives a flit three edges later
    task automatic single_write_latency(input port_e port);
        logic [31:0] bits;
        int          start;
        int          seen;
        draw_bits(PAYLOAD_W, bits);
        seen = flits_seen;
        @(posedge clk);
        if (port == PORT_WEST)
        begin
            west_wr_en <= 1'b1;
            west_din   <= bits[PAYLOAD_W-1:0];
        end
        else
        begin
            east_wr_en <= 1'b1;
            east_din   <= bits[PAYLOAD_W-1:0];
        end
        @(negedge clk);
        start = cycle;
        @(posedge clk);
        west_wr_en <= 1'b0;
        east_wr_en <= 1'b0;
        while (flits_seen == seen)
            @(posedge clk);
        check_value("out_valid latency", 32'(last_valid_cycle - start), 32'd3);
        check_value("out_flit.src", 32'(last_flit.src), 32'(port));
        check_value("out_flit.data", 32'(last_flit.data), 32'(bits[PAYLOAD_W-1:0]));
    endtask

    // Random writes on both ports while the drain level flips
    task automatic random_traffic();
        logic [31:0] bits;
        repeat (RANDOM_CYCLES)
        begin
            @(posedge clk);
            draw_bits(1, bits);
            west_wr_en <= bits[0];
            draw_bits(PAYLOAD_W, bits);
            west_din <= bits[PAYLOAD_W-1:0];
            draw_bits(1, bits);
            east_wr_en <= bits[0];
            draw_bits(PAYLOAD_W, bits);
            east_din <= bits[PAYLOAD_W-1:0];
            // Flip about one cycle in four
            draw_bits(2, bits);
            if (bits[1:0] == 2'b00)
                drain_en <= !drain_en;
        end
        @(posedge clk);
        west_wr_en <= 1'b0;
        east_wr_en <= 1'b0;
        drain_en   <= 1'b1;
    endtask

    initial
    begin
        rst_n      = 1'b1;
        west_wr_en = 1'b0;
        west_din   = '0;
        east_wr_en = 1'b0;
        east_din   = '0;
        drain_en   = 1'b0;
        lfsr_state = LFSR_SEED;
        cycle      = 0;
        flits_seen = 0;
        last_valid_cycle = 0;
        last_flit  = '0;
        alt_on     = 1'b0;
        alt_idx    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b0;

        // Clean state out of reset
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("out_flit", 32'(out_flit), 32'd0);
        check_value("west_status.empty", 32'(west_status.empty), 32'd1);
        check_value("west_status.count", 32'(west_status.count), 32'd0);
        check_value("east_status.empty", 32'(east_status.empty), 32'd1);
        check_value("east_status.count", 32'(east_status.count), 32'd0);

        fill_ports();
        drain_alternating();
        single_write_latency(PORT_WEST);
        wait_idle();
        single_write_latency(PORT_EAST);
        wait_idle();
        random_traffic();
        wait_idle();

        // Both ports drained
        @(negedge clk);
        check_value("west_status.empty", 32'(west_status.empty), 32'd1);
        check_value("east_status.empty", 32'(east_status.empty), 32'd1);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/west_east_merge.sv ====
`default_nettype none

module west_east_merge
    import noc_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         west_wr_en,
    input  payload_t     west_din,
    input  logic         east_wr_en,
    input  payload_t     east_din,
    input  logic         drain_en,
    output logic         out_valid,
    output flit_t        out_flit,
    output fifo_status_t west_status,
    output fifo_status_t east_status
);

    ///////////////////////////////
    // Internal wiring
    ///////////////////////////////

    // Pop strobes from the arbiter
    logic west_rd_en;
    logic east_rd_en;

    // Popped words back to the arbiter
    payload_t west_dout;
    payload_t east_dout;

    // West input port
    port_fifo u_west_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (west_wr_en),
        .rd_en  (west_rd_en),
        .din    (west_din),
        .dout   (west_dout),
        .status (west_status)
    );

    // East input port
    port_fifo u_east_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (east_wr_en),
        .rd_en  (east_rd_en),
        .din    (east_din),
        .dout   (east_dout),
        .status (east_status)
    );

    // Round-robin merge onto the single output
    rr_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .drain_en    (drain_en),
        .west_status (west_status),
        .east_status (east_status),
        .west_dout   (west_dout),
        .east_dout   (east_dout),
        .west_rd_en  (west_rd_en),
        .east_rd_en  (east_rd_en),
        .out_valid   (out_valid),
        .out_flit    (out_flit)
    );

endmodule

`default_nettype wire

// ==== design/rr_arbiter.sv ====
`default_nettype none

module rr_arbiter
    import noc_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         drain_en,
    input  fifo_status_t west_status,
    input  fifo_status_t east_status,
    input  payload_t     west_dout,
    input  payload_t     east_dout,
    output logic         west_rd_en,
    output logic         east_rd_en,
    output logic         out_valid,
    output flit_t        out_flit
);

    ///////////////////////////////
    // Grant decision
    ///////////////////////////////

    // Port granted last, next tie goes to the other one
    grant_e last_grant;
    grant_e next_grant;

    logic west_req;
    logic east_req;

    // Requests only while draining and only from non-empty FIFOs
    assign west_req = drain_en && !west_status.empty;
    assign east_req = drain_en && !east_status.empty;

    // West wins when alone or when east was served last
    always_comb
    begin
        west_rd_en = 1'b0;
        east_rd_en = 1'b0;
        if (west_req && east_req)
        begin
            if (last_grant == LAST_EAST)
                west_rd_en = 1'b1;
            else
                east_rd_en = 1'b1;
        end
        else if (west_req)
        begin
            west_rd_en = 1'b1;
        end
        else if (east_req)
        begin
            east_rd_en = 1'b1;
        end
    end

    // Record every grant, hold when idle
    always_comb
    begin
        next_grant = last_grant;
        if (west_rd_en)
            next_grant = LAST_WEST;
        else if (east_rd_en)
            next_grant = LAST_EAST;
    end

    // After reset east counts as last, so west takes the first tie
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            last_grant <= LAST_EAST;
        else
            last_grant <= next_grant;
    end

    ///////////////////////////////
    // Read pipeline
    ///////////////////////////////

    // Stage one, word lands on the FIFO dout at the same edge
    logic  pend;
    port_e pend_src;

    // Word selected from the FIFO that was read
    payload_t sel_data;

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            pend     <= 1'b0;
            pend_src <= PORT_WEST;
        end
        else
        begin
            pend <= west_rd_en || east_rd_en;
            // Tag only changes on a read
            if (east_rd_en)
                pend_src <= PORT_EAST;
            else if (west_rd_en)
                pend_src <= PORT_WEST;
        end
    end

    assign sel_data = (pend_src == PORT_EAST) ? east_dout : west_dout;

    // Stage two, registered flit with a one-cycle valid
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            out_valid <= 1'b0;
            out_flit  <= '0;
        end
        else
        begin
            out_valid <= pend;
            if (pend)
                out_flit <= '{src: pend_src, data: sel_data};
        end
    end

endmodule

`default_nettype wire

// ==== design/port_fifo.sv ====
`default_nettype none

module port_fifo
    import noc_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         wr_en,
    input  logic         rd_en,
    input  payload_t     din,
    output payload_t     dout,
    output fifo_status_t status
);

    ///////////////////////////////
    // Storage and pointers
    ///////////////////////////////

    // Entry array, written only on accepted pushes
    payload_t mem [FIFO_DEPTH];

    // Pointers wrap naturally at the power-of-two depth
    ptr_t wr_ptr;
    ptr_t rd_ptr;

    // Occupancy
    count_t count;

    logic empty;
    logic full;
    logic wr_ok;
    logic rd_ok;

    // Flags decoded from the counter
    assign empty = (count == '0);
    assign full  = (count == count_t'(FIFO_DEPTH));

    // Strobes that really take effect
    // A push into a full FIFO is lost even with a pop in the same cycle
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    assign status = '{empty: empty, full: full, count: count};

    ///////////////////////////////
    // Counter
    ///////////////////////////////

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            count <= '0;
        end
        else if (wr_ok && rd_ok)
        begin
            // Push and pop together, level unchanged
            count <= count;
        end
        else if (wr_ok)
        begin
            count <= count + count_t'(1);
        end
        else if (rd_ok)
        begin
            count <= count - count_t'(1);
        end
    end

    // Pointer advance on accepted strobes
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_ok)
                wr_ptr <= wr_ptr + ptr_t'(1);
            if (rd_ok)
                rd_ptr <= rd_ptr + ptr_t'(1);
        end
    end

    // Memory write
    always_ff @(posedge clk)
    begin
        if (wr_ok)
            mem[wr_ptr] <= din;
    end

    // Registered read port
    // Holds the last popped word until the next pop
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            dout <= '0;
        else if (rd_ok)
            dout <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

// ==== design/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

    ///////////////////////////////
    // Sizes
    ///////////////////////////////

    // Flit payload width
    localparam int PAYLOAD_W = 8;

    // Entries per port FIFO, kept a power of two so the pointers wrap by themselves
    localparam int FIFO_DEPTH = 8;

    // Pointer width
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // One extra bit so the counter can reach the full depth
    localparam int CNT_W = PTR_W + 1;

    ///////////////////////////////
    // Types
    ///////////////////////////////

    typedef logic [PAYLOAD_W-1:0] payload_t;
    typedef logic [PTR_W-1:0]     ptr_t;
    typedef logic [CNT_W-1:0]     count_t;

    // Source port tag carried with each flit
    typedef enum logic {
        PORT_WEST = 1'b0,
        PORT_EAST = 1'b1
    } port_e;

    // Output flit
    typedef struct packed {
        port_e    src;
        payload_t data;
    } flit_t;

    // FIFO flags and occupancy
    typedef struct packed {
        logic   empty;
        logic   full;
        count_t count;
    } fifo_status_t;

    // Arbiter state, the port granted last
    typedef enum logic {
        LAST_WEST = 1'b0,
        LAST_EAST = 1'b1
    } grant_e;

endpackage

`default_nettype wire
